// File: Makefile
# Verilator build and run of the memory controller testbench.
# A failing check ends the run through $fatal, so the exit status carries the result.

BUILD_DIR = build

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module memCtrlTb -Mdir $(BUILD_DIR) -f memCtrl.f
	./$(BUILD_DIR)/VmemCtrlTb

clean:
	rm -rf $(BUILD_DIR)

// File: memCtrl.f
src/memPkg.sv
src/byteCounter.sv
src/loadAssembler.sv
src/memPortDriver.sv
src/memArbiter.sv
src/memCtrl.sv
verif/ramModel.sv
verif/memCtrlTb.sv

// File: src/byteCounter.sv
`timescale 1ns/1ns
`default_nettype none

module byteCounter (
    input  logic        clk,
    input  logic        rst,
    input  logic        clear,
    input  logic        advance,
    output logic [2:0]  byteIndex
);

    // highest index any transaction reaches
    localparam logic [2:0] MaxIndex = 3'd4;

    logic atMax;

    assign atMax = byteIndex == MaxIndex;

    always_ff @(posedge clk) begin
        if (rst) begin
            byteIndex <= 3'd0;
        end else if (clear) begin
            byteIndex <= 3'd0;
        end else if (advance && !atMax) begin
            byteIndex <= byteIndex + 3'd1;
        end
    end

endmodule

`default_nettype wire

// File: src/loadAssembler.sv
`timescale 1ns/1ns
`default_nettype none

module loadAssembler (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          clear,
    input  logic                          capture,
    input  logic [2:0]                    byteIndex,
    input  logic [7:0]                    memDin,
    output logic [memPkg::DataWidth-1:0]  word
);

    logic [memPkg::DataWidth-1:0] buffer;
    logic [1:0]                   lane;
    logic [2:0]                   prevIndex;

    // read data lags the address by one byte cycle
    assign prevIndex = byteIndex - 3'd1;
    assign lane      = prevIndex[1:0];

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            buffer <= '0;
        end else if (capture) begin
            buffer[{lane, 3'b000} +: 8] <= memDin;
        end
    end

    // last byte goes straight through in the done cycle;
    // untouched lanes stay zero, which zero-extends short loads
    always_comb begin
        word = buffer;
        if (capture) begin
            word[{lane, 3'b000} +: 8] = memDin;
        end
    end

endmodule

`default_nettype wire

// File: src/memArbiter.sv
`timescale 1ns/1ns
`default_nettype none

module memArbiter (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              ioBufferFull,
    input  logic              fetchEn,
    input  logic              dataEn,
    input  logic              dataStore,
    input  memPkg::memLen     dataLen,
    input  logic [2:0]        byteIndex,
    output memPkg::memState   state,
    output logic              advance,
    output logic              clear,
    output logic              capture,
    output logic              memWe,
    output logic              fetchDone,
    output logic              dataDone,
    output memPkg::memOwner   busyOwner
);

    logic              stall;
    logic              busy;
    logic              isRead;
    logic              atEnd;
    logic              lastLive;
    memPkg::memLen     curLen;
    memPkg::memState   nextState;

    assign stall  = !rdy || ioBufferFull;
    assign busy   = state != memPkg::stIdle;
    assign isRead = (state == memPkg::stLoad) || (state == memPkg::stFetch);

    // fetches are always a full word
    assign curLen = (state == memPkg::stFetch) ? memPkg::lenWord : dataLen;
    assign atEnd  = busy && (byteIndex == curLen);

    always_comb begin
        nextState = state;
        case (state)
            memPkg::stIdle: begin
                // data unit has priority
                if (dataEn) begin
                    nextState = dataStore ? memPkg::stStore : memPkg::stLoad;
                end else if (fetchEn) begin
                    nextState = memPkg::stFetch;
                end
            end
            default: begin
                if (atEnd) begin
                    nextState = memPkg::stIdle;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= memPkg::stIdle;
            lastLive <= 1'b0;
        end else begin
            lastLive <= !stall;
            if (!stall) begin
                state <= nextState;
            end
        end
    end

    assign advance = busy && !atEnd && !stall;
    assign clear   = !stall && (!busy || atEnd);

    // memDin holds the byte of the last live cycle, even if this cycle stalls.
    // After a stall it holds a reissued read, which is not taken.
    assign capture = isRead && (byteIndex != 3'd0) && lastLive;

    assign memWe = (state == memPkg::stStore) && !atEnd && !stall;

    assign fetchDone = (state == memPkg::stFetch) && atEnd && !stall;
    assign dataDone  = ((state == memPkg::stLoad) || (state == memPkg::stStore))
                       && atEnd && !stall;

    always_comb begin
        case (state)
            memPkg::stFetch: busyOwner = memPkg::ownFetch;
            memPkg::stLoad:  busyOwner = memPkg::ownData;
            memPkg::stStore: busyOwner = memPkg::ownData;
            default:         busyOwner = memPkg::ownNone;
        endcase
    end

endmodule

`default_nettype wire

// File: src/memCtrl.sv
`timescale 1ns/1ns
`default_nettype none

module memCtrl #(
    parameter int AddrWidth = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          ioBufferFull,

    // instruction fetch
    input  logic                          fetchEn,
    input  logic [AddrWidth-1:0]          fetchAddr,
    output logic                          fetchDone,
    output logic [memPkg::DataWidth-1:0]  fetchInst,

    // data unit
    input  logic                          dataEn,
    input  logic                          dataStore,
    input  memPkg::memLen                 dataLen,
    input  logic [AddrWidth-1:0]          dataAddr,
    input  logic [memPkg::DataWidth-1:0]  storeData,
    output logic                          dataDone,
    output logic [memPkg::DataWidth-1:0]  loadData,

    output memPkg::memOwner               busyOwner,

    // byte-wide RAM
    input  logic [7:0]                    memDin,
    output logic [AddrWidth-1:0]          memAddr,
    output logic [7:0]                    memDout,
    output logic                          memWe
);

    memPkg::memState                state;
    logic [2:0]                     byteIndex;
    logic                           advance;
    logic                           clear;
    logic                           capture;
    logic [memPkg::DataWidth-1:0]   word;

    memArbiter memArbiter_i (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .dataEn       (dataEn),
        .dataStore    (dataStore),
        .dataLen      (dataLen),
        .byteIndex    (byteIndex),
        .state        (state),
        .advance      (advance),
        .clear        (clear),
        .capture      (capture),
        .memWe        (memWe),
        .fetchDone    (fetchDone),
        .dataDone     (dataDone),
        .busyOwner    (busyOwner)
    );

    byteCounter byteCounter_i (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .advance   (advance),
        .byteIndex (byteIndex)
    );

    loadAssembler loadAssembler_i (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .capture   (capture),
        .byteIndex (byteIndex),
        .memDin    (memDin),
        .word      (word)
    );

    memPortDriver #(
        .AddrWidth (AddrWidth)
    ) memPortDriver_i (
        .state     (state),
        .byteIndex (byteIndex),
        .fetchAddr (fetchAddr),
        .dataAddr  (dataAddr),
        .storeData (storeData),
        .memAddr   (memAddr),
        .memDout   (memDout)
    );

    // word is only meaningful in the done cycle
    assign fetchInst = fetchDone ? word : '0;
    assign loadData  = dataDone ? word : '0;

endmodule

`default_nettype wire

// File: src/memPkg.sv
`default_nettype none

package memPkg;

    // width of a load, store or instruction word
    localparam int DataWidth = 32;

    // arbiter state
    typedef enum logic [1:0] {
        stIdle  = 2'd0,
        stFetch = 2'd1,
        stLoad  = 2'd2,
        stStore = 2'd3
    } memState;

    // requester that currently owns the RAM
    typedef enum logic [1:0] {
        ownNone  = 2'd0,
        ownData  = 2'd1,
        ownFetch = 2'd2
    } memOwner;

    // access length in bytes, compared directly with the byte index
    typedef enum logic [2:0] {
        lenByte = 3'd1,
        lenHalf = 3'd2,
        lenWord = 3'd4
    } memLen;

endpackage

`default_nettype wire

// File: src/memPortDriver.sv
`timescale 1ns/1ns
`default_nettype none

module memPortDriver #(
    parameter int AddrWidth = 32
) (
    input  memPkg::memState               state,
    input  logic [2:0]                    byteIndex,
    input  logic [AddrWidth-1:0]          fetchAddr,
    input  logic [AddrWidth-1:0]          dataAddr,
    input  logic [memPkg::DataWidth-1:0]  storeData,
    output logic [AddrWidth-1:0]          memAddr,
    output logic [7:0]                    memDout
);

    logic                 isData;
    logic                 isStore;
    logic [AddrWidth-1:0] baseAddr;
    logic [AddrWidth-1:0] offset;

    assign isData  = (state == memPkg::stLoad) || (state == memPkg::stStore);
    assign isStore = state == memPkg::stStore;

    // idle also points at the fetch address
    assign baseAddr = isData ? dataAddr : fetchAddr;
    assign offset   = AddrWidth'(byteIndex);
    assign memAddr  = baseAddr + offset;

    // little-endian store lanes; index 4 never writes
    always_comb begin
        if (isStore) begin
            memDout = storeData[{byteIndex[1:0], 3'b000} +: 8];
        end else begin
            memDout = 8'h00;
        end
    end

endmodule

`default_nettype wire

// File: verif/memCtrlTb.sv
`timescale 1ns/1ns
`default_nettype none

module memCtrlTb;

    localparam int AddrWidth = 16;
    localparam int Timeout   = 200;

    logic                          clk = 1'b0;
    logic                          rst;
    logic                          rdy;
    logic                          ioBufferFull;
    logic                          fetchEn;
    logic [AddrWidth-1:0]          fetchAddr;
    logic                          fetchDone;
    logic [memPkg::DataWidth-1:0]  fetchInst;
    logic                          dataEn;
    logic                          dataStore;
    memPkg::memLen                 dataLen;
    logic [AddrWidth-1:0]          dataAddr;
    logic [memPkg::DataWidth-1:0]  storeData;
    logic                          dataDone;
    logic [memPkg::DataWidth-1:0]  loadData;
    memPkg::memOwner               busyOwner;
    logic [7:0]                    memDin;
    logic [AddrWidth-1:0]          memAddr;
    logic [7:0]                    memDout;
    logic                          memWe;

    logic [7:0]            shadow [0:(1<<AddrWidth)-1];
    logic [AddrWidth-1:0]  storedAddrs [$];
    integer                seed;
    logic                  stallOn;
    string                 testName;

    memCtrl #(
        .AddrWidth (AddrWidth)
    ) memCtrl_i (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dataEn       (dataEn),
        .dataStore    (dataStore),
        .dataLen      (dataLen),
        .dataAddr     (dataAddr),
        .storeData    (storeData),
        .dataDone     (dataDone),
        .loadData     (loadData),
        .busyOwner    (busyOwner),
        .memDin       (memDin),
        .memAddr      (memAddr),
        .memDout      (memDout),
        .memWe        (memWe)
    );

    ramModel #(
        .AddrWidth (AddrWidth)
    ) ramModel_i (
        .clk    (clk),
        .rst    (rst),
        .addr   (memAddr),
        .we     (memWe),
        .wrData (memDout),
        .rdData (memDin)
    );

    always #50 clk = ~clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input logic [memPkg::DataWidth-1:0] expected,
                             input logic [memPkg::DataWidth-1:0] actual);
        if (actual !== expected) begin
            failRun($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic checkOwner(input string name, input memPkg::memOwner expected,
                              input memPkg::memOwner actual);
        if (actual !== expected) begin
            failRun($sformatf("Fail %s: expected %s, actual %s", name, expected.name(),
                              actual.name()));
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            failRun($sformatf("Fail %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic checkCycles(input string name, input int expected, input int actual);
        if (actual != expected) begin
            failRun($sformatf("Fail %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    // little-endian, zero-extended word from the shadow
    function automatic logic [memPkg::DataWidth-1:0] expectedWord(
        input logic [AddrWidth-1:0] addr,
        input memPkg::memLen        len
    );
        logic [memPkg::DataWidth-1:0] w;
        w = '0;
        for (int i = 0; i < int'(len); i++) begin
            w[i*8 +: 8] = shadow[addr + AddrWidth'(i)];
        end
        return w;
    endfunction

    function automatic memPkg::memLen lenAt(input int k);
        case (k)
            0:       return memPkg::lenByte;
            1:       return memPkg::lenHalf;
            default: return memPkg::lenWord;
        endcase
    endfunction

    // compares results and mirrors stores
    always @(negedge clk) begin
        if (rst) begin
            for (int a = 0; a < (1 << AddrWidth); a++) begin
                shadow[a] = 8'(a * 3) ^ 8'(a >> 8) ^ 8'h5A;
            end
        end else begin
            if (!rdy || ioBufferFull) begin
                checkFlag({testName, " fetchDone in stall"}, 1'b0, fetchDone);
                checkFlag({testName, " dataDone in stall"}, 1'b0, dataDone);
                checkFlag({testName, " memWe in stall"}, 1'b0, memWe);
            end
            if (fetchDone) begin
                checkWord({testName, " fetchInst"}, expectedWord(fetchAddr, memPkg::lenWord),
                          fetchInst);
            end
            if (dataDone && !dataStore) begin
                checkWord({testName, " loadData"}, expectedWord(dataAddr, dataLen), loadData);
            end
            if (dataDone && dataStore) begin
                for (int i = 0; i < int'(dataLen); i++) begin
                    shadow[dataAddr + AddrWidth'(i)] = storeData[i*8 +: 8];
                end
            end
        end
    end

    // one rising edge, with random back-pressure when enabled
    task automatic nextEdge();
        logic [31:0] r;
        @(posedge clk);
        if (stallOn) begin
            r = $random(seed);
            rdy          <= r[1:0] != 2'd0;
            ioBufferFull <= r[3:2] == 2'd0;
        end else begin
            rdy          <= 1'b1;
            ioBufferFull <= 1'b0;
        end
    endtask

    // live cycles before done: one to grant, then one per byte
    task automatic waitDone(input logic isFetch, input int len, input memPkg::memOwner owner);
        int   cycles;
        int   live;
        logic seen;
        logic thisDone;
        logic otherDone;
        cycles = 0;
        live   = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(negedge clk);
            cycles++;
            if (cycles > Timeout) begin
                failRun($sformatf("%s: no done pulse within %0d cycles", testName, Timeout));
            end
            thisDone  = isFetch ? fetchDone : dataDone;
            otherDone = isFetch ? dataDone : fetchDone;
            checkFlag({testName, " other done"}, 1'b0, otherDone);
            checkOwner({testName, " busyOwner"}, (live > 0) ? owner : memPkg::ownNone,
                       busyOwner);
            if (thisDone) begin
                checkCycles({testName, " cycles to done"}, len + 1, live);
                seen = 1'b1;
            end else begin
                if (rdy && !ioBufferFull) begin
                    live++;
                end
                nextEdge();
            end
        end
    endtask

    task automatic runFetch(input logic [AddrWidth-1:0] addr);
        nextEdge();
        fetchEn   <= 1'b1;
        fetchAddr <= addr;
        dataEn    <= 1'b0;
        waitDone(1'b1, 4, memPkg::ownFetch);
        nextEdge();
        fetchEn <= 1'b0;
    endtask

    task automatic runData(input logic store, input memPkg::memLen len,
                           input logic [AddrWidth-1:0] addr,
                           input logic [memPkg::DataWidth-1:0] wdata);
        nextEdge();
        fetchEn   <= 1'b0;
        dataEn    <= 1'b1;
        dataStore <= store;
        dataLen   <= len;
        dataAddr  <= addr;
        storeData <= wdata;
        waitDone(1'b0, int'(len), memPkg::ownData);
        nextEdge();
        dataEn <= 1'b0;
    endtask

    // both requests rise together, data must win
    task automatic runDataThenFetch(input logic [AddrWidth-1:0] dAddr,
                                    input logic [AddrWidth-1:0] fAddr);
        nextEdge();
        dataEn    <= 1'b1;
        dataStore <= 1'b0;
        dataLen   <= memPkg::lenWord;
        dataAddr  <= dAddr;
        fetchEn   <= 1'b1;
        fetchAddr <= fAddr;
        waitDone(1'b0, 4, memPkg::ownData);
        nextEdge();
        dataEn <= 1'b0;
        waitDone(1'b1, 4, memPkg::ownFetch);
        nextEdge();
        fetchEn <= 1'b0;
    endtask

    initial begin
        logic [31:0]           r;
        logic [31:0]           d;
        logic [AddrWidth-1:0]  a;

        seed         = 32'h14796078;
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn      = 1'b0;
        fetchAddr    = '0;
        dataEn       = 1'b0;
        dataStore    = 1'b0;
        dataLen      = memPkg::lenByte;
        dataAddr     = '0;
        storeData    = '0;
        stallOn      = 1'b0;
        testName     = "reset";

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        testName = "idle after reset";
        repeat (4) begin
            @(negedge clk);
            checkFlag({testName, " memWe"}, 1'b0, memWe);
            checkFlag({testName, " fetchDone"}, 1'b0, fetchDone);
            checkFlag({testName, " dataDone"}, 1'b0, dataDone);
            checkOwner({testName, " busyOwner"}, memPkg::ownNone, busyOwner);
        end

        testName = "fetch";
        repeat (8) begin
            r = $random(seed);
            runFetch(r[AddrWidth-1:0]);
        end

        testName = "load";
        for (int k = 0; k < 3; k++) begin
            repeat (4) begin
                r = $random(seed);
                runData(1'b0, lenAt(k), r[AddrWidth-1:0], '0);
            end
        end

        // stores, then word loads that cover both neighbours
        testName = "store";
        for (int k = 0; k < 3; k++) begin
            repeat (4) begin
                r = $random(seed);
                d = $random(seed);
                a = r[AddrWidth-1:0];
                runData(1'b1, lenAt(k), a, d);
                runData(1'b0, memPkg::lenWord, a - AddrWidth'(2), '0);
                runData(1'b0, memPkg::lenWord, a + AddrWidth'(2), '0);
            end
        end

        testName = "data before fetch";
        repeat (4) begin
            r = $random(seed);
            d = $random(seed);
            runDataThenFetch(r[AddrWidth-1:0], d[AddrWidth-1:0]);
        end

        testName = "stall";
        stallOn  = 1'b1;
        repeat (3) begin
            for (int k = 0; k < 3; k++) begin
                r = $random(seed);
                d = $random(seed);
                a = r[AddrWidth-1:0];
                runFetch(d[AddrWidth-1:0]);
                runData(1'b1, lenAt(k), a, d);
                storedAddrs.push_back(a);
                runData(1'b0, lenAt(k), a, '0);
                runData(1'b0, memPkg::lenWord, a - AddrWidth'(2), '0);
            end
            r = $random(seed);
            runDataThenFetch(r[AddrWidth-1:0], r[31:32-AddrWidth]);
        end
        stallOn = 1'b0;

        // a write repeated during a stall would show up here
        testName = "reload after stall";
        foreach (storedAddrs[i]) begin
            runData(1'b0, memPkg::lenWord, storedAddrs[i] - AddrWidth'(2), '0);
            runData(1'b0, memPkg::lenWord, storedAddrs[i] + AddrWidth'(2), '0);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/ramModel.sv
`timescale 1ns/1ns
`default_nettype none

module ramModel #(
    parameter int AddrWidth = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [AddrWidth-1:0]  addr,
    input  logic                  we,
    input  logic [7:0]            wrData,
    output logic [7:0]            rdData
);

    localparam int Depth = 1 << AddrWidth;

    logic [7:0] mem [0:Depth-1];

    always @(posedge clk) begin
        if (rst) begin
            // power-up image, every address bit matters
            for (int a = 0; a < Depth; a++) begin
                mem[a] = 8'(a * 3) ^ 8'(a >> 8) ^ 8'h5A;
            end
            rdData <= 8'h00;
        end else begin
            // read returns the old byte on a write cycle
            rdData <= mem[addr];
            if (we) begin
                mem[addr] = wrData;
            end
        end
    end

endmodule

`default_nettype wire
